//--- Bender.yml
package:
  name: rv_cpu

sources:
  - common/rv_pkg.sv
  - common/decode_if.sv
  - hw/cpu/rv_control.sv
  - hw/cpu/rv_decoder.sv
  - hw/cpu/rv_execute.sv
  - hw/cpu/rv_regfile.sv
  - hw/cpu/rv_cpu.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/rv_cpu_checker.sv
      - testbench/tb_rv_cpu.sv

//--- common/decode_if.sv
`timescale 1ns/1ps

interface decode_if;
	import rv_pkg::*;

	// instruction class from the opcode
	op_class_e op_class;
	logic [2:0] funct3;
	logic [6:0] funct7;
	// register indices
	logic [REG_AW-1:0] rs1;
	logic [REG_AW-1:0] rs2;
	logic [REG_AW-1:0] rd;
	// sign-extended immediate of whatever format
	logic [XLEN-1:0] imm;

	// decoder side
	modport dec (
		output op_class, funct3, funct7, rs1, rs2, rd, imm
	);

	// control, execute, regfile
	modport view (
		input op_class, funct3, funct7, rs1, rs2, rd, imm
	);

endinterface

//--- common/rv_pkg.sv
package rv_pkg;

	// datapath and register file widths
	localparam int XLEN = 32;
	localparam int NREGS = 32;
	localparam int REG_AW = 5;
	// first fetch address out of reset
	localparam logic [XLEN-1:0] RESET_PC = '0;

	// major opcodes
	localparam logic [6:0] OPC_R = 7'b0110011;
	localparam logic [6:0] OPC_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;

	// load/store access size
	localparam logic [2:0] F3_B = 3'b000;
	localparam logic [2:0] F3_H = 3'b001;
	localparam logic [2:0] F3_W = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	// alu ops, shared by R and I forms
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// branch compares
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// sequencer states
	localparam logic [2:0] ST_FETCH = 3'd0;
	localparam logic [2:0] ST_DECODE = 3'd1;
	localparam logic [2:0] ST_EXECUTE = 3'd2;
	localparam logic [2:0] ST_MEM = 3'd3;
	localparam logic [2:0] ST_WB = 3'd4;

	typedef enum logic [3:0] {
		CLS_R,
		CLS_IMM,
		CLS_LOAD,
		CLS_JALR,
		CLS_STORE,
		CLS_BRANCH,
		CLS_LUI,
		CLS_AUIPC,
		CLS_JAL,
		CLS_ILLEGAL
	} op_class_e;

	// instruction formats, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm31_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word, six views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} rv_instr_u;

endpackage

//--- flist.f
common/rv_pkg.sv
common/decode_if.sv
hw/cpu/rv_control.sv
hw/cpu/rv_decoder.sv
hw/cpu/rv_execute.sv
hw/cpu/rv_regfile.sv
hw/cpu/rv_cpu.sv
testbench/tb_clock.sv
testbench/rv_cpu_checker.sv
testbench/tb_rv_cpu.sv

//--- hw/cpu/rv_control.sv
`timescale 1ns/1ps

module rv_control (
	input logic clk,
	input logic reset,
	input logic i_dmem_waitrequest,
	decode_if.view i_dec,
	output logic o_fetch,
	output logic o_decode_en,
	output logic o_exec_en,
	output logic o_mem_rd,
	output logic o_mem_wr,
	output logic o_load_capture,
	output logic o_wb_en,
	output logic o_pc_commit
);
	import rv_pkg::*;

	logic [2:0] state;
	logic [2:0] next_state;
	logic is_load;
	logic is_store;
	logic writes_rd;

	// class of the instruction in flight
	assign is_load = (i_dec.op_class == CLS_LOAD);
	assign is_store = (i_dec.op_class == CLS_STORE);

	// stores, branches and no-ops leave rd alone
	always_comb begin
		case (i_dec.op_class)
			CLS_R, CLS_IMM, CLS_LOAD, CLS_JALR, CLS_LUI, CLS_AUIPC, CLS_JAL: begin
				writes_rd = 1'b1;
			end
			default: begin
				writes_rd = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_FETCH;
		end else begin
			state <= next_state;
		end
	end

	// FETCH -> DECODE -> EXECUTE -> [MEM] -> WB
	always_comb begin
		case (state)
			ST_FETCH: begin
				next_state = ST_DECODE;
			end
			ST_DECODE: begin
				next_state = ST_EXECUTE;
			end
			ST_EXECUTE: begin
				// only loads and stores touch the data port
				next_state = (is_load || is_store) ? ST_MEM : ST_WB;
			end
			ST_MEM: begin
				// hold the request under back-pressure
				next_state = i_dmem_waitrequest ? ST_MEM : ST_WB;
			end
			ST_WB: begin
				next_state = ST_FETCH;
			end
			default: begin
				next_state = ST_FETCH;
			end
		endcase
	end

	// strobes straight from the state
	assign o_fetch = (state == ST_FETCH);
	assign o_decode_en = (state == ST_DECODE);
	assign o_exec_en = (state == ST_EXECUTE);
	assign o_mem_rd = (state == ST_MEM) && is_load;
	assign o_mem_wr = (state == ST_MEM) && is_store;
	// read completes on the first edge without waitrequest
	assign o_load_capture = o_mem_rd && !i_dmem_waitrequest;
	// every instruction commits PC here, branches included
	assign o_pc_commit = (state == ST_WB);
	assign o_wb_en = (state == ST_WB) && writes_rd;

endmodule

//--- hw/cpu/rv_cpu.sv
`timescale 1ns/1ps

module rv_cpu (
	input logic clk,
	input logic reset,

	// instruction fetch port, fixed one-cycle read
	output logic [rv_pkg::XLEN-1:0] o_imem_addr,
	output logic o_imem_rd,
	input logic [rv_pkg::XLEN-1:0] i_imem_rddata,

	// load/store port with waitrequest
	output logic [rv_pkg::XLEN-1:0] o_dmem_addr,
	output logic o_dmem_rd,
	output logic o_dmem_wr,
	output logic [rv_pkg::XLEN-1:0] o_dmem_wrdata,
	output logic [3:0] o_dmem_byte_en,
	input logic [rv_pkg::XLEN-1:0] i_dmem_rddata,
	input logic i_dmem_waitrequest
);
	import rv_pkg::*;

	// sequencer strobes
	logic decode_en;
	logic exec_en;
	logic load_capture;
	logic wb_en;
	logic pc_commit;

	// regfile read data into execute
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] result;

	// decoded fields, valid from end of DECODE
	decode_if dec_bus ();

	rv_control u_control (
		.clk (clk),
		.reset (reset),
		.i_dmem_waitrequest (i_dmem_waitrequest),
		.i_dec (dec_bus.view),
		.o_fetch (o_imem_rd),
		.o_decode_en (decode_en),
		.o_exec_en (exec_en),
		.o_mem_rd (o_dmem_rd),
		.o_mem_wr (o_dmem_wr),
		.o_load_capture (load_capture),
		.o_wb_en (wb_en),
		.o_pc_commit (pc_commit)
	);

	rv_decoder u_decoder (
		.clk (clk),
		.reset (reset),
		.i_decode_en (decode_en),
		.i_instr (i_imem_rddata),
		.o_dec (dec_bus.dec)
	);

	rv_execute u_execute (
		.clk (clk),
		.reset (reset),
		.i_exec_en (exec_en),
		.i_pc_commit (pc_commit),
		.i_rs1_data (rs1_data),
		.i_rs2_data (rs2_data),
		.i_dec (dec_bus.view),
		.o_pc (o_imem_addr),
		.o_result (result),
		.o_ldst_addr (o_dmem_addr),
		.o_wrdata (o_dmem_wrdata),
		.o_byte_en (o_dmem_byte_en)
	);

	rv_regfile u_regfile (
		.clk (clk),
		.reset (reset),
		.i_wb_en (wb_en),
		.i_load_capture (load_capture),
		.i_result (result),
		.i_dmem_rddata (i_dmem_rddata),
		.i_dec (dec_bus.view),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

endmodule

//--- hw/cpu/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
	input logic clk,
	input logic reset,
	input logic i_decode_en,
	input logic [rv_pkg::XLEN-1:0] i_instr,
	decode_if.dec o_dec
);
	import rv_pkg::*;

	rv_instr_u instr;
	op_class_e cls;
	logic [XLEN-1:0] imm;

	// fetched word arrives the cycle after the imem read
	assign instr = i_instr;

	// opcode classification, anything unknown becomes a no-op
	always_comb begin
		case (instr.r.opcode)
			OPC_R: cls = CLS_R;
			OPC_IMM: cls = CLS_IMM;
			OPC_LOAD: cls = CLS_LOAD;
			OPC_JALR: cls = CLS_JALR;
			OPC_STORE: cls = CLS_STORE;
			OPC_BRANCH: cls = CLS_BRANCH;
			OPC_LUI: cls = CLS_LUI;
			OPC_AUIPC: cls = CLS_AUIPC;
			OPC_JAL: cls = CLS_JAL;
			default: cls = CLS_ILLEGAL;
		endcase
	end

	// immediate per format, sign bit is always instr[31]
	always_comb begin
		case (cls)
			CLS_IMM, CLS_LOAD, CLS_JALR: begin
				imm = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
			end
			CLS_STORE: begin
				imm = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
			end
			CLS_BRANCH: begin
				imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
					instr.b.imm4_1, 1'b0};
			end
			CLS_LUI, CLS_AUIPC: begin
				imm = {instr.u.imm31_12, 12'b0};
			end
			CLS_JAL: begin
				imm = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
					instr.j.imm10_1, 1'b0};
			end
			default: begin
				// R-type and no-op carry none
				imm = '0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_dec.op_class <= CLS_ILLEGAL;
		end else if (i_decode_en) begin
			o_dec.op_class <= cls;
		end
	end

	// index fields sit at the same bits in every format
	always_ff @(posedge clk) begin
		if (i_decode_en) begin
			o_dec.funct3 <= instr.r.funct3;
			o_dec.funct7 <= instr.r.funct7;
			o_dec.rs1 <= instr.r.rs1;
			o_dec.rs2 <= instr.r.rs2;
			o_dec.rd <= instr.r.rd;
			o_dec.imm <= imm;
		end
	end

endmodule

//--- hw/cpu/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
	input logic clk,
	input logic reset,
	input logic i_exec_en,
	input logic i_pc_commit,
	input logic [rv_pkg::XLEN-1:0] i_rs1_data,
	input logic [rv_pkg::XLEN-1:0] i_rs2_data,
	decode_if.view i_dec,
	output logic [rv_pkg::XLEN-1:0] o_pc,
	output logic [rv_pkg::XLEN-1:0] o_result,
	output logic [rv_pkg::XLEN-1:0] o_ldst_addr,
	output logic [rv_pkg::XLEN-1:0] o_wrdata,
	output logic [3:0] o_byte_en
);
	import rv_pkg::*;

	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] next_pc_q;
	logic [XLEN-1:0] op_b;
	logic [4:0] shamt;
	logic [XLEN-1:0] alu;
	logic [XLEN-1:0] result;
	logic [XLEN-1:0] next_pc;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] pc_plus_imm;
	logic taken;
	logic [XLEN-1:0] wrdata;
	logic [3:0] byte_en;

	assign pc_plus4 = pc_q + 32'd4;
	assign pc_plus_imm = pc_q + i_dec.imm;

	// second operand is rs2 only for R-type
	assign op_b = (i_dec.op_class == CLS_R) ? i_rs2_data : i_dec.imm;
	assign shamt = op_b[4:0];

	always_comb begin
		case (i_dec.funct3)
			F3_ADD: begin
				// sub exists only in R form
				if (i_dec.op_class == CLS_R && i_dec.funct7[5]) begin
					alu = i_rs1_data - op_b;
				end else begin
					alu = i_rs1_data + op_b;
				end
			end
			F3_SLL: alu = i_rs1_data << shamt;
			F3_SLT: alu = {31'b0, $signed(i_rs1_data) < $signed(op_b)};
			F3_SLTU: alu = {31'b0, i_rs1_data < op_b};
			F3_XOR: alu = i_rs1_data ^ op_b;
			F3_SR: begin
				// funct7[5] is imm[10] for srai as well
				if (i_dec.funct7[5]) begin
					alu = $unsigned($signed(i_rs1_data) >>> shamt);
				end else begin
					alu = i_rs1_data >> shamt;
				end
			end
			F3_OR: alu = i_rs1_data | op_b;
			default: alu = i_rs1_data & op_b;
		endcase
	end

	// branch condition
	always_comb begin
		case (i_dec.funct3)
			F3_BEQ: taken = (i_rs1_data == i_rs2_data);
			F3_BNE: taken = (i_rs1_data != i_rs2_data);
			F3_BLT: taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
			F3_BGE: taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
			F3_BLTU: taken = (i_rs1_data < i_rs2_data);
			F3_BGEU: taken = (i_rs1_data >= i_rs2_data);
			default: taken = 1'b0;
		endcase
	end

	// result and next pc by class
	always_comb begin
		result = alu;
		next_pc = pc_plus4;
		case (i_dec.op_class)
			CLS_JAL: begin
				result = pc_plus4;
				next_pc = pc_plus_imm;
			end
			CLS_JALR: begin
				result = pc_plus4;
				next_pc = (i_rs1_data + i_dec.imm) & ~32'd1;
			end
			CLS_BRANCH: next_pc = taken ? pc_plus_imm : pc_plus4;
			CLS_AUIPC: result = pc_plus_imm;
			CLS_LUI: result = i_dec.imm;
			default: ;
		endcase
	end

	// low lane only, upper bits zero
	always_comb begin
		case (i_dec.funct3)
			F3_B, F3_BU: begin
				byte_en = 4'b0001;
				wrdata = {24'b0, i_rs2_data[7:0]};
			end
			F3_H, F3_HU: begin
				byte_en = 4'b0011;
				wrdata = {16'b0, i_rs2_data[15:0]};
			end
			F3_W: begin
				byte_en = 4'b1111;
				wrdata = i_rs2_data;
			end
			default: begin
				byte_en = 4'b1111;
				wrdata = i_rs2_data;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_exec_en) begin
			o_result <= result;
			next_pc_q <= next_pc;
			o_ldst_addr <= i_rs1_data + i_dec.imm;
			o_wrdata <= wrdata;
			o_byte_en <= byte_en;
		end
	end

	// pc moves only at the end of writeback
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc_q <= RESET_PC;
		end else if (i_pc_commit) begin
			pc_q <= next_pc_q;
		end
	end

	assign o_pc = pc_q;

endmodule

//--- hw/cpu/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
	input logic clk,
	input logic reset,
	input logic i_wb_en,
	input logic i_load_capture,
	input logic [rv_pkg::XLEN-1:0] i_result,
	input logic [rv_pkg::XLEN-1:0] i_dmem_rddata,
	decode_if.view i_dec,
	output logic [rv_pkg::XLEN-1:0] o_rs1_data,
	output logic [rv_pkg::XLEN-1:0] o_rs2_data
);
	import rv_pkg::*;

	logic [XLEN-1:0] regs [NREGS];
	logic [XLEN-1:0] ld_word;
	logic [XLEN-1:0] ld_ext;
	logic [XLEN-1:0] wr_val;

	// x0 is hardwired
	assign o_rs1_data = (i_dec.rs1 == '0) ? '0 : regs[i_dec.rs1];
	assign o_rs2_data = (i_dec.rs2 == '0) ? '0 : regs[i_dec.rs2];

	// read word held from MEM until writeback
	always_ff @(posedge clk) begin
		if (i_load_capture) begin
			ld_word <= i_dmem_rddata;
		end
	end

	// extend from the low lane
	always_comb begin
		case (i_dec.funct3)
			F3_B: ld_ext = {{24{ld_word[7]}}, ld_word[7:0]};
			F3_H: ld_ext = {{16{ld_word[15]}}, ld_word[15:0]};
			F3_BU: ld_ext = {24'b0, ld_word[7:0]};
			F3_HU: ld_ext = {16'b0, ld_word[15:0]};
			F3_W: ld_ext = ld_word;
			default: ld_ext = ld_word;
		endcase
	end

	assign wr_val = (i_dec.op_class == CLS_LOAD) ? ld_ext : i_result;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb_en && i_dec.rd != '0) begin
			regs[i_dec.rd] <= wr_val;
		end
	end

endmodule

//--- testbench/rv_cpu_checker.sv
`timescale 1ns/1ps

module rv_cpu_checker (
	input logic clk,
	input logic reset,
	input logic o_imem_rd,
	input logic o_dmem_rd,
	input logic o_dmem_wr,
	input logic [rv_pkg::XLEN-1:0] o_dmem_addr,
	input logic [rv_pkg::XLEN-1:0] o_dmem_wrdata,
	input logic [3:0] o_dmem_byte_en,
	input logic i_dmem_waitrequest
);

	// read back by the testbench top
	int unsigned fail_count = 0;
	logic req;

	assign req = o_dmem_rd || o_dmem_wr;

	// never read and write together
	a_one_dir: assert property (@(posedge clk) disable iff (reset)
		!(o_dmem_rd && o_dmem_wr))
	else begin
		$error("o_dmem_rd and o_dmem_wr high together");
		fail_count++;
	end

	// request frozen while the slave stalls
	a_hold: assert property (@(posedge clk) disable iff (reset)
		req && i_dmem_waitrequest |=>
		$stable({o_dmem_rd, o_dmem_wr, o_dmem_addr, o_dmem_wrdata, o_dmem_byte_en}))
	else begin
		$error("data request changed under waitrequest");
		fail_count++;
	end

	// request drops right after it completes
	a_release: assert property (@(posedge clk) disable iff (reset)
		req && !i_dmem_waitrequest |=> !req)
	else begin
		$error("data request still high after completion");
		fail_count++;
	end

	// fetch is a single-cycle pulse, at least 4 apart
	a_fetch_gap: assert property (@(posedge clk) disable iff (reset)
		o_imem_rd |=> !o_imem_rd [*3])
	else begin
		$error("o_imem_rd pulses closer than 4 cycles");
		fail_count++;
	end

	// no data access in between: exactly 4 apart
	a_fetch_period: assert property (@(posedge clk) disable iff (reset)
		o_imem_rd ##1 (!o_imem_rd && !req) [*3] |=> o_imem_rd)
	else begin
		$error("non-memory instruction did not take 4 cycles");
		fail_count++;
	end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset
);

	// free running clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset held for a few edges, dropped on a falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
	end

endmodule

//--- testbench/tb_rv_cpu.sv
`timescale 1ns/1ps

module tb_rv_cpu;
	import rv_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 4;
	// longest run of waitrequest in a row
	localparam int MAX_STALL = 3;
	localparam logic [31:0] SIG_BASE = 32'h100;
	localparam logic [31:0] POISON_ADDR = 32'h1F0;
	localparam logic [31:0] END_ADDR = 32'h1F8;
	localparam logic [31:0] LD_ADDR = 32'h80;
	localparam logic [31:0] LD_WORD = 32'h1234F687;
	localparam logic [31:0] POISON = 32'hDEADB0EF;
	// operands held in x1, x2, x3
	localparam logic [31:0] A_VAL = 32'hFFFFFFF9;
	localparam logic [31:0] B_VAL = 32'h12345678;
	localparam logic [31:0] C_VAL = 32'd5;

	logic clk;
	logic reset;
	logic [XLEN-1:0] o_imem_addr;
	logic o_imem_rd;
	logic [XLEN-1:0] i_imem_rddata;
	logic [XLEN-1:0] o_dmem_addr;
	logic o_dmem_rd;
	logic o_dmem_wr;
	logic [XLEN-1:0] o_dmem_wrdata;
	logic [3:0] o_dmem_byte_en;
	logic [XLEN-1:0] i_dmem_rddata;
	logic i_dmem_waitrequest;

	logic [31:0] imem [256];
	logic [31:0] dmem [128];
	// expected signature, one word per slot
	logic [31:0] sig_data [64];
	logic [3:0] sig_be [64];
	int n_sig = 0;
	int sig_hits = 0;
	int pc_w = 0;
	int n_fall = 0;
	int seed = 63;
	int errors = 0;
	int checks = 0;
	int stall_cnt = 0;
	int timeout_ns = 0;
	logic stall;
	logic fetch_pending = 1'b0;
	logic [31:0] fetch_addr = '0;
	logic out_of_reset = 1'b0;
	logic prog_ready = 1'b0;
	logic done = 1'b0;

	tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.clk (clk),
		.reset (reset)
	);

	rv_cpu DUT (
		.clk (clk),
		.reset (reset),
		.o_imem_addr (o_imem_addr),
		.o_imem_rd (o_imem_rd),
		.i_imem_rddata (i_imem_rddata),
		.o_dmem_addr (o_dmem_addr),
		.o_dmem_rd (o_dmem_rd),
		.o_dmem_wr (o_dmem_wr),
		.o_dmem_wrdata (o_dmem_wrdata),
		.o_dmem_byte_en (o_dmem_byte_en),
		.i_dmem_rddata (i_dmem_rddata),
		.i_dmem_waitrequest (i_dmem_waitrequest)
	);

	bind rv_cpu rv_cpu_checker u_checker (
		.clk (clk),
		.reset (reset),
		.o_imem_rd (o_imem_rd),
		.o_dmem_rd (o_dmem_rd),
		.o_dmem_wr (o_dmem_wr),
		.o_dmem_addr (o_dmem_addr),
		.o_dmem_wrdata (o_dmem_wrdata),
		.o_dmem_byte_en (o_dmem_byte_en),
		.i_dmem_waitrequest (i_dmem_waitrequest)
	);

	// instruction encoders, one per format
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		r_type = {f7, rs2, rs1, f3, rd, OPC_R};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		i_type = {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		s_type = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [2:0] f3);
		b_type = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		u_type = {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
		j_type = {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[pc_w] = word;
		pc_w++;
	endtask

	// store rs to the next signature slot and remember what it must hold
	task automatic sig_store(input logic [2:0] f3, input logic [4:0] rs,
		input logic [31:0] data, input logic [3:0] be);
		logic [11:0] off;
		off = SIG_BASE + 4 * n_sig;
		emit(s_type(off, rs, 5'd0, f3));
		sig_data[n_sig] = data;
		sig_be[n_sig] = be;
		n_sig++;
	endtask

	// instruction writes x4, then x4 goes out
	task automatic alu_check(input logic [31:0] word, input logic [31:0] exp);
		emit(word);
		sig_store(F3_W, 5'd4, exp, 4'hF);
	endtask

	task automatic load_check(input logic [2:0] f3, input logic [31:0] exp);
		emit(i_type(LD_ADDR[11:0], 5'd0, f3, 5'd5, OPC_LOAD));
		sig_store(F3_W, 5'd5, exp, 4'hF);
	endtask

	// taken skips a poison store, not taken bumps x7
	task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input bit taken);
		emit(b_type(13'd8, rs1, rs2, f3));
		if (taken) begin
			emit(s_type(POISON_ADDR[11:0], 5'd6, 5'd0, F3_W));
		end else begin
			emit(i_type(12'd1, 5'd7, F3_ADD, 5'd7, OPC_IMM));
			n_fall++;
		end
	endtask

	task automatic build_program();
		logic [31:0] apc;
		// unknown opcode tagged with the word address
		for (int i = 0; i < 256; i++) begin
			imem[i] = {i[24:0], 7'h7F};
		end
		for (int i = 0; i < 128; i++) begin
			dmem[i] = 32'hA5A50000 ^ (i << 2);
		end
		dmem[LD_ADDR[8:2]] = LD_WORD;
		// operands and poison
		emit(i_type(12'hFF9, 5'd0, F3_ADD, 5'd1, OPC_IMM));
		emit(u_type(20'h12345, 5'd2, OPC_LUI));
		emit(i_type(12'h678, 5'd2, F3_ADD, 5'd2, OPC_IMM));
		emit(i_type(12'd5, 5'd0, F3_ADD, 5'd3, OPC_IMM));
		emit(u_type(20'hDEADB, 5'd6, OPC_LUI));
		emit(i_type(12'h0EF, 5'd6, F3_ADD, 5'd6, OPC_IMM));
		sig_store(F3_W, 5'd1, A_VAL, 4'hF);
		sig_store(F3_W, 5'd2, B_VAL, 4'hF);
		// R-type
		alu_check(r_type(7'h00, 5'd2, 5'd1, F3_ADD, 5'd4), A_VAL + B_VAL);
		alu_check(r_type(7'h20, 5'd2, 5'd1, F3_ADD, 5'd4), A_VAL - B_VAL);
		alu_check(r_type(7'h00, 5'd2, 5'd1, F3_XOR, 5'd4), A_VAL ^ B_VAL);
		alu_check(r_type(7'h00, 5'd2, 5'd1, F3_OR, 5'd4), A_VAL | B_VAL);
		alu_check(r_type(7'h00, 5'd2, 5'd1, F3_AND, 5'd4), A_VAL & B_VAL);
		alu_check(r_type(7'h00, 5'd3, 5'd2, F3_SLL, 5'd4), B_VAL << C_VAL);
		alu_check(r_type(7'h00, 5'd3, 5'd1, F3_SR, 5'd4), A_VAL >> C_VAL);
		alu_check(r_type(7'h20, 5'd3, 5'd1, F3_SR, 5'd4), {{5{A_VAL[31]}}, A_VAL[31:5]});
		// -7 below 0x12345678 signed, above it unsigned
		alu_check(r_type(7'h00, 5'd2, 5'd1, F3_SLT, 5'd4), 32'd1);
		alu_check(r_type(7'h00, 5'd2, 5'd1, F3_SLTU, 5'd4), 32'd0);
		// I-type with sign-extended immediates
		alu_check(i_type(12'hFFF, 5'd2, F3_ADD, 5'd4, OPC_IMM), B_VAL - 1);
		alu_check(i_type(12'h0F0, 5'd2, F3_XOR, 5'd4, OPC_IMM), B_VAL ^ 32'h0F0);
		alu_check(i_type(12'h801, 5'd2, F3_OR, 5'd4, OPC_IMM), B_VAL | 32'hFFFFF801);
		alu_check(i_type(12'h7FF, 5'd2, F3_AND, 5'd4, OPC_IMM), B_VAL & 32'h7FF);
		alu_check(i_type(12'h004, 5'd2, F3_SLL, 5'd4, OPC_IMM), B_VAL << 4);
		alu_check(i_type(12'h01C, 5'd1, F3_SR, 5'd4, OPC_IMM), A_VAL >> 28);
		alu_check(i_type(12'h402, 5'd1, F3_SR, 5'd4, OPC_IMM), {{2{A_VAL[31]}}, A_VAL[31:2]});
		alu_check(i_type(12'h000, 5'd1, F3_SLT, 5'd4, OPC_IMM), 32'd1);
		alu_check(i_type(12'hFFF, 5'd3, F3_SLTU, 5'd4, OPC_IMM), 32'd1);
		// x0 ignores writes
		emit(i_type(12'd99, 5'd0, F3_ADD, 5'd0, OPC_IMM));
		emit(r_type(7'h00, 5'd2, 5'd1, F3_ADD, 5'd0));
		sig_store(F3_W, 5'd0, 32'd0, 4'hF);
		// loads take the low lane
		load_check(F3_B, {{24{LD_WORD[7]}}, LD_WORD[7:0]});
		load_check(F3_H, {{16{LD_WORD[15]}}, LD_WORD[15:0]});
		load_check(F3_W, LD_WORD);
		load_check(F3_BU, {24'b0, LD_WORD[7:0]});
		load_check(F3_HU, {16'b0, LD_WORD[15:0]});
		// store sizes
		sig_store(F3_B, 5'd2, {24'b0, B_VAL[7:0]}, 4'b0001);
		sig_store(F3_H, 5'd2, {16'b0, B_VAL[15:0]}, 4'b0011);
		sig_store(F3_W, 5'd2, B_VAL, 4'b1111);
		// x1 = -7, x2 = 0x12345678, x3 = 5
		branch_case(F3_BEQ, 5'd3, 5'd3, 1'b1);
		branch_case(F3_BEQ, 5'd1, 5'd2, 1'b0);
		branch_case(F3_BNE, 5'd1, 5'd2, 1'b1);
		branch_case(F3_BNE, 5'd3, 5'd3, 1'b0);
		branch_case(F3_BLT, 5'd1, 5'd3, 1'b1);
		branch_case(F3_BLT, 5'd3, 5'd1, 1'b0);
		branch_case(F3_BGE, 5'd3, 5'd1, 1'b1);
		branch_case(F3_BGE, 5'd1, 5'd3, 1'b0);
		branch_case(F3_BLTU, 5'd3, 5'd1, 1'b1);
		branch_case(F3_BLTU, 5'd1, 5'd3, 1'b0);
		branch_case(F3_BGEU, 5'd1, 5'd3, 1'b1);
		branch_case(F3_BGEU, 5'd3, 5'd1, 1'b0);
		sig_store(F3_W, 5'd7, n_fall, 4'hF);
		// jal over a poison store with link pc+4
		apc = pc_w * 4;
		emit(j_type(21'd8, 5'd8));
		emit(s_type(POISON_ADDR[11:0], 5'd6, 5'd0, F3_W));
		sig_store(F3_W, 5'd8, apc + 4, 4'hF);
		// auipc gives the base and jalr with an odd offset lands on base+16
		apc = pc_w * 4;
		emit(u_type(20'h0, 5'd9, OPC_AUIPC));
		sig_store(F3_W, 5'd9, apc, 4'hF);
		emit(i_type(12'd17, 5'd9, 3'b000, 5'd10, OPC_JALR));
		emit(s_type(POISON_ADDR[11:0], 5'd6, 5'd0, F3_W));
		sig_store(F3_W, 5'd10, apc + 12, 4'hF);
		apc = pc_w * 4;
		emit(u_type(20'h00001, 5'd11, OPC_AUIPC));
		sig_store(F3_W, 5'd11, apc + 32'h1000, 4'hF);
		emit(u_type(20'hABCDE, 5'd12, OPC_LUI));
		sig_store(F3_W, 5'd12, 32'hABCDE000, 4'hF);
		// end marker, then spin in place
		emit(s_type(END_ADDR[11:0], 5'd0, 5'd0, F3_W));
		emit(j_type(21'd0, 5'd0));
	endtask

	// byte-enabled write, then signature and poison checks
	task automatic complete_write();
		int idx;
		for (int i = 0; i < 4; i++) begin
			if (o_dmem_byte_en[i]) begin
				dmem[o_dmem_addr[8:2]][8*i +: 8] = o_dmem_wrdata[8*i +: 8];
			end
		end
		checks++;
		assert (o_dmem_wrdata != POISON) else begin
			$display("a skipped instruction stored the poison value at %h", o_dmem_addr);
			errors++;
		end
		if (o_dmem_addr == END_ADDR) begin
			done = 1'b1;
		end else if (o_dmem_addr >= SIG_BASE && o_dmem_addr < SIG_BASE + 4 * n_sig) begin
			idx = (o_dmem_addr - SIG_BASE) >> 2;
			sig_hits++;
			checks += 2;
			assert (o_dmem_wrdata == sig_data[idx]) else begin
				$display("[ERROR] o_dmem_wrdata slot %0d: got %h, expected %h",
					idx, o_dmem_wrdata, sig_data[idx]);
				errors++;
			end
			assert (o_dmem_byte_en == sig_be[idx]) else begin
				$display("[ERROR] o_dmem_byte_en slot %0d: got %h, expected %h",
					idx, o_dmem_byte_en, sig_be[idx]);
				errors++;
			end
		end
	endtask

	// memory model moving all inputs on the falling edge
	initial begin
		// start once the clock is running
		@(posedge clk);
		forever begin
			@(negedge clk);
			// fetch from the previous cycle returns now
			if (fetch_pending) begin
				i_imem_rddata = imem[fetch_addr[9:2]];
			end
			if (reset) begin
				checks++;
				assert (!o_dmem_rd && !o_dmem_wr) else begin
					$display("data request raised while reset is held");
					errors++;
				end
			end else if (!out_of_reset) begin
				out_of_reset = 1'b1;
				checks++;
				assert (!o_dmem_rd && !o_dmem_wr && fetch_pending && fetch_addr == RESET_PC)
				else begin
					$display("first cycle after reset did not fetch from the reset address");
					errors++;
				end
			end
			fetch_pending = o_imem_rd;
			fetch_addr = o_imem_addr;
			// random back-pressure with bounded run length
			stall = !reset && stall_cnt < MAX_STALL && ($random(seed) & 1) != 0;
			stall_cnt = stall ? stall_cnt + 1 : 0;
			i_dmem_waitrequest = stall;
			if (!stall && o_dmem_rd) begin
				i_dmem_rddata = dmem[o_dmem_addr[8:2]];
			end
			if (!stall && o_dmem_wr) begin
				complete_write();
			end
		end
	end

	initial begin
		i_imem_rddata = '0;
		i_dmem_rddata = '0;
		i_dmem_waitrequest = 1'b0;
		build_program();
		// worst case per instruction, plus reset and slack
		timeout_ns = (pc_w * (5 + MAX_STALL) + RESET_CYCLES + 40) * CLK_PERIOD;
		prog_ready = 1'b1;
		wait (done);
		@(posedge clk);
		checks++;
		assert (sig_hits == n_sig) else begin
			$display("only %0d of %0d signature stores arrived", sig_hits, n_sig);
			errors++;
		end
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, DUT.u_checker.fail_count);
		if (errors == 0 && DUT.u_checker.fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (prog_ready);
		#(timeout_ns);
		$display("the program did not reach its end store within %0d ns", timeout_ns);
		$display("tests failed");
		$finish;
	end

endmodule
